// File: hdl/alarmPkg.sv
package alarmPkg;

	typedef logic [5:0] sixtyT;       // seconds or minutes, 0..59
	typedef logic [6:0] segT;         // active low, bit 6 = a, bit 0 = g
	typedef logic [2:0] digitIdxT;
	typedef logic [3:0] apbAddrT;
	typedef logic [31:0] apbDataT;
	typedef logic [15:0] halfPeriodT; // clock cycles per half wave

	localparam apbAddrT CTRL_ADDR = 4'd0;    // bit 0 alarm enable
	localparam apbAddrT ALARM_ADDR = 4'd4;   // sec 5:0, min 13:8
	localparam apbAddrT TIME_ADDR = 4'd8;    // same layout as alarm
	localparam apbAddrT STATUS_ADDR = 4'd12; // read only, bit 0 ringing

	localparam sixtyT MAX_SIXTY = 6'd59;

	// decimal digit to segment pattern
	localparam segT segDigits [10] = '{
		7'b0000001, // 0
		7'b1001111, // 1
		7'b0010010, // 2
		7'b0000110, // 3
		7'b1001100, // 4
		7'b0100100, // 5
		7'b0100000, // 6
		7'b0001111, // 7
		7'b0000000, // 8
		7'b0000100  // 9
	};

	localparam int MELODY_LEN = 8;

	localparam halfPeriodT melodyHalfPeriod [MELODY_LEN] = '{
		16'd20,
		16'd18,
		16'd16,
		16'd15,
		16'd13,
		16'd12,
		16'd10,
		16'd9
	};

endpackage

// File: hdl/alarmRegs.sv
`timescale 1ns/1ps

module alarmRegs import alarmPkg::*; (
	input logic Clk,
	input logic rstN,
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input apbAddrT pAddr,
	input apbDataT pWData,
	input sixtyT curSec,
	input sixtyT curMin,
	input logic ringing,
	output apbDataT pRData,
	output logic pReady,
	output logic pSlvErr,
	output logic alarmEn,
	output sixtyT alarmSec,
	output sixtyT alarmMin,
	output logic loadTime,
	output sixtyT loadSec,
	output sixtyT loadMin
);

	logic access;
	logic addrOk;
	logic badAccess;
	logic wrEn;

	function automatic sixtyT clampSixty(input logic [5:0] v);
		return (v > MAX_SIXTY) ? MAX_SIXTY : v;
	endfunction

	assign access = pSel & pEnable;
	assign addrOk = (pAddr == CTRL_ADDR) || (pAddr == ALARM_ADDR) ||
		(pAddr == TIME_ADDR) || (pAddr == STATUS_ADDR);
	assign badAccess = !addrOk || (pWrite && (pAddr == STATUS_ADDR));
	assign wrEn = access & pWrite & ~badAccess;

	assign pReady = 1'b1; // no wait states
	assign pSlvErr = access & badAccess;

	// time load goes straight to the counter on the access edge
	assign loadTime = wrEn && (pAddr == TIME_ADDR);
	assign loadSec = clampSixty(pWData[5:0]);
	assign loadMin = clampSixty(pWData[13:8]);

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			alarmEn <= 1'b0;
			alarmSec <= '0;
			alarmMin <= '0;
		end else if (wrEn) begin
			if (pAddr == CTRL_ADDR)
				alarmEn <= pWData[0];
			if (pAddr == ALARM_ADDR) begin
				alarmSec <= clampSixty(pWData[5:0]);
				alarmMin <= clampSixty(pWData[13:8]);
			end
		end
	end

	always_comb begin
		pRData = '0;
		if (access && !pWrite) begin
			case (pAddr)
				CTRL_ADDR: pRData[0] = alarmEn;
				ALARM_ADDR: begin
					pRData[5:0] = alarmSec;
					pRData[13:8] = alarmMin;
				end
				TIME_ADDR: begin
					pRData[5:0] = curSec;
					pRData[13:8] = curMin;
				end
				STATUS_ADDR: pRData[0] = ringing;
				default: pRData = '0; // error response, no data
			endcase
		end
	end

endmodule

// File: hdl/tickGen.sv
`timescale 1ns/1ps

module tickGen #(
	parameter int unsigned CLKS_PER_SEC = 100_000_000,
	parameter int unsigned CLKS_PER_DIGIT = 125_000
) (
	input logic Clk,
	input logic rstN,
	output logic secTick,
	output logic digitTick
);

	localparam int SEC_W = $clog2(CLKS_PER_SEC);
	localparam int DIGIT_W = $clog2(CLKS_PER_DIGIT);

	logic [SEC_W-1:0] secCnt;
	logic [DIGIT_W-1:0] digitCnt;

	assign secTick = (secCnt == SEC_W'(CLKS_PER_SEC - 1));
	assign digitTick = (digitCnt == DIGIT_W'(CLKS_PER_DIGIT - 1));

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			secCnt <= '0;
			digitCnt <= '0;
		end else begin
			secCnt <= secTick ? '0 : secCnt + 1'b1;
			digitCnt <= digitTick ? '0 : digitCnt + 1'b1; // scan rate
		end
	end

endmodule

// File: hdl/timeCounter.sv
`timescale 1ns/1ps

module timeCounter import alarmPkg::*; (
	input logic Clk,
	input logic rstN,
	input logic secTick,
	input logic loadTime,
	input sixtyT loadSec,
	input sixtyT loadMin,
	output sixtyT curSec,
	output sixtyT curMin
);

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			curSec <= '0;
			curMin <= '0;
		end else if (loadTime) begin // load wins over tick
			curSec <= loadSec;
			curMin <= loadMin;
		end else if (secTick) begin
			if (curSec == MAX_SIXTY) begin
				curSec <= '0;
				curMin <= (curMin == MAX_SIXTY) ? '0 : curMin + 1'b1;
			end else begin
				curSec <= curSec + 1'b1;
			end
		end
	end

endmodule

// File: hdl/alarmControl.sv
`timescale 1ns/1ps

module alarmControl import alarmPkg::*; #(
	parameter int unsigned RING_SECONDS = 10
) (
	input logic Clk,
	input logic rstN,
	input logic secTick,
	input logic alarmEn,
	input sixtyT alarmSec,
	input sixtyT alarmMin,
	input sixtyT curSec,
	input sixtyT curMin,
	output logic ringing
);

	localparam int RING_W = $clog2(RING_SECONDS + 1);

	typedef enum logic [1:0] {
		stIdle,
		stRing,
		stServed // ring over, match not yet gone
	} ringStateT;

	ringStateT state;
	logic [RING_W-1:0] ringCnt;
	logic match;

	assign match = alarmEn && (curSec == alarmSec) && (curMin == alarmMin);
	assign ringing = (state == stRing);

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			state <= stIdle;
			ringCnt <= '0;
		end else begin
			case (state)
				stIdle: begin
					ringCnt <= '0;
					if (match)
						state <= stRing;
				end
				stRing: begin
					if (!alarmEn) begin
						state <= stIdle;
					end else if (secTick) begin
						if (ringCnt == RING_W'(RING_SECONDS - 1))
							state <= stServed;
						ringCnt <= ringCnt + 1'b1;
					end
				end
				stServed: begin
					if (!match)
						state <= stIdle;
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

// File: hdl/toneGen.sv
`timescale 1ns/1ps

module toneGen import alarmPkg::*; #(
	parameter int unsigned CLKS_PER_NOTE = 25_000_000
) (
	input logic Clk,
	input logic rstN,
	input logic ringing,
	output logic audioOut
);

	localparam int NOTE_W = $clog2(CLKS_PER_NOTE);
	localparam int IDX_W = $clog2(MELODY_LEN);

	logic [NOTE_W-1:0] noteCnt;
	logic [IDX_W-1:0] noteIdx;
	halfPeriodT halfCnt;
	logic toneLvl;
	logic noteDone;
	logic halfDone;

	assign noteDone = (noteCnt == NOTE_W'(CLKS_PER_NOTE - 1));
	assign halfDone = (halfCnt == melodyHalfPeriod[noteIdx] - 1'b1);

	// silent line sits high
	assign audioOut = toneLvl | ~ringing;

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			noteCnt <= '0;
			noteIdx <= '0;
			halfCnt <= '0;
			toneLvl <= 1'b1;
		end else if (!ringing) begin
			noteCnt <= '0; // next ring starts at entry 0
			noteIdx <= '0;
			halfCnt <= '0;
			toneLvl <= 1'b1;
		end else begin
			if (noteDone) begin
				noteCnt <= '0;
				halfCnt <= '0;
				noteIdx <= (noteIdx == IDX_W'(MELODY_LEN - 1)) ? '0 : noteIdx + 1'b1;
			end else begin
				noteCnt <= noteCnt + 1'b1;
				if (halfDone) begin
					halfCnt <= '0;
					toneLvl <= ~toneLvl;
				end else begin
					halfCnt <= halfCnt + 1'b1;
				end
			end
		end
	end

endmodule

// File: hdl/displayScan.sv
`timescale 1ns/1ps

module displayScan import alarmPkg::*; (
	input logic Clk,
	input logic rstN,
	input logic digitTick,
	input sixtyT curSec,
	input sixtyT curMin,
	input sixtyT alarmSec,
	input sixtyT alarmMin,
	output logic [7:0] an,
	output segT seg,
	output logic dp
);

	digitIdxT scanIdx;
	sixtyT selVal;
	logic [3:0] onesDigit;
	logic [3:0] tensDigit;
	logic [3:0] showDigit;

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN)
			scanIdx <= '0;
		else if (digitTick)
			scanIdx <= scanIdx + 1'b1; // wraps after digit 7
	end

	// pairs of digits share one value
	always_comb begin
		case (scanIdx[2:1])
			2'd0: selVal = curSec;
			2'd1: selVal = curMin;
			2'd2: selVal = alarmSec;
			default: selVal = alarmMin;
		endcase
	end

	assign onesDigit = 4'(selVal % 6'd10);
	assign tensDigit = 4'(selVal / 6'd10);
	assign showDigit = scanIdx[0] ? tensDigit : onesDigit;

	assign seg = segDigits[showDigit];
	assign an = ~(8'b0000_0001 << scanIdx);
	assign dp = !((scanIdx == 3'd2) || (scanIdx == 3'd6)); // between min and sec

endmodule

// File: hdl/alarmClockTop.sv
`timescale 1ns/1ps

module alarmClockTop import alarmPkg::*; #(
	parameter int unsigned CLKS_PER_SEC = 100_000_000,
	parameter int unsigned CLKS_PER_DIGIT = 125_000,
	parameter int unsigned CLKS_PER_NOTE = 25_000_000,
	parameter int unsigned RING_SECONDS = 10
) (
	input logic Clk,
	input logic rstN,
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input apbAddrT pAddr,
	input apbDataT pWData,
	output apbDataT pRData,
	output logic pReady,
	output logic pSlvErr,
	output logic [7:0] an,
	output segT seg,
	output logic dp,
	output logic audioOut,
	output logic ringing
);

	logic secTick;
	logic digitTick;
	logic alarmEn;
	sixtyT alarmSec;
	sixtyT alarmMin;
	logic loadTime;
	sixtyT loadSec;
	sixtyT loadMin;
	sixtyT curSec;
	sixtyT curMin;

	alarmRegs i_alarmRegs (
		.Clk(Clk),
		.rstN(rstN),
		.pSel(pSel),
		.pEnable(pEnable),
		.pWrite(pWrite),
		.pAddr(pAddr),
		.pWData(pWData),
		.curSec(curSec),
		.curMin(curMin),
		.ringing(ringing),
		.pRData(pRData),
		.pReady(pReady),
		.pSlvErr(pSlvErr),
		.alarmEn(alarmEn),
		.alarmSec(alarmSec),
		.alarmMin(alarmMin),
		.loadTime(loadTime),
		.loadSec(loadSec),
		.loadMin(loadMin)
	);

	tickGen #(
		.CLKS_PER_SEC(CLKS_PER_SEC),
		.CLKS_PER_DIGIT(CLKS_PER_DIGIT)
	) i_tickGen (
		.Clk(Clk),
		.rstN(rstN),
		.secTick(secTick),
		.digitTick(digitTick)
	);

	timeCounter i_timeCounter (
		.Clk(Clk),
		.rstN(rstN),
		.secTick(secTick),
		.loadTime(loadTime),
		.loadSec(loadSec),
		.loadMin(loadMin),
		.curSec(curSec),
		.curMin(curMin)
	);

	alarmControl #(
		.RING_SECONDS(RING_SECONDS)
	) i_alarmControl (
		.Clk(Clk),
		.rstN(rstN),
		.secTick(secTick),
		.alarmEn(alarmEn),
		.alarmSec(alarmSec),
		.alarmMin(alarmMin),
		.curSec(curSec),
		.curMin(curMin),
		.ringing(ringing)
	);

	toneGen #(
		.CLKS_PER_NOTE(CLKS_PER_NOTE)
	) i_toneGen (
		.Clk(Clk),
		.rstN(rstN),
		.ringing(ringing),
		.audioOut(audioOut)
	);

	displayScan i_displayScan (
		.Clk(Clk),
		.rstN(rstN),
		.digitTick(digitTick),
		.curSec(curSec),
		.curMin(curMin),
		.alarmSec(alarmSec),
		.alarmMin(alarmMin),
		.an(an),
		.seg(seg),
		.dp(dp)
	);

endmodule

// File: verif/alarmClockTb.sv
`timescale 1ns/1ps

module alarmClockTb import alarmPkg::*; ();

	localparam int CLK_PERIOD = 4;
	localparam int CLKS_PER_SEC = 200;
	localparam int CLKS_PER_DIGIT = 5;
	localparam int CLKS_PER_NOTE = 100;
	localparam int RING_SECONDS = 3;
	// regs 1, time 6, display 2, ring 4 + ring + 1, disable 4 (seconds)
	localparam int RUN_CYCLES = (1 + 6 + 2 + (5 + RING_SECONDS) + 4) * CLKS_PER_SEC;

	logic Clk, rstN, pSel, pEnable, pWrite;
	apbAddrT pAddr;
	apbDataT pWData, pRData;
	logic pReady, pSlvErr, dp, audioOut, ringing;
	logic [7:0] an;
	segT seg;
	int errCount;
	int checkCount;

	alarmClockTop #(
		.CLKS_PER_SEC(CLKS_PER_SEC),
		.CLKS_PER_DIGIT(CLKS_PER_DIGIT),
		.CLKS_PER_NOTE(CLKS_PER_NOTE),
		.RING_SECONDS(RING_SECONDS)
	) i_alarmClockTop (.*);

	initial begin
		Clk = 1'b0;
		forever #(CLK_PERIOD / 2) Clk = ~Clk;
	end

	initial begin
		#(2 * RUN_CYCLES * CLK_PERIOD);
		$display("timeout, the tests did not finish in time");
		$display("Checks failed");
		$finish;
	end

	task automatic nextCycle();
		@(posedge Clk);
		#1; // drive point
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		assert (got === exp) else begin
			$display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
			errCount++;
		end
	endtask

	task automatic checkEither(input string name, input logic [31:0] got,
		input logic [31:0] expA, input logic [31:0] expB);
		checkCount++;
		assert (got === expA || got === expB) else begin
			$display("CHECK FAILED %s got 0x%0h expected 0x%0h or 0x%0h", name, got, expA, expB);
			errCount++;
		end
	endtask

	task automatic checkTrue(input bit cond, input string what);
		checkCount++;
		assert (cond) else begin
			$display("%s", what);
			errCount++;
		end
	endtask

	function automatic apbDataT timeWord(input int minutes, input int seconds);
		apbDataT w;
		w = '0;
		w[13:8] = minutes[5:0];
		w[5:0] = seconds[5:0];
		return w;
	endfunction

	function automatic apbDataT timeAfter(input int minutes, input int seconds, input int n);
		int total;
		total = (minutes * 60 + seconds + n) % 3600;
		return timeWord(total / 60, total % 60);
	endfunction

	task automatic apbWrite(input apbAddrT addr, input apbDataT data, input logic expErr);
		pSel = 1'b1;
		pEnable = 1'b0;
		pWrite = 1'b1;
		pAddr = addr;
		pWData = data;
		nextCycle();
		pEnable = 1'b1; // access phase
		#1;
		checkValue("pReady", pReady, 1'b1);
		checkValue("pSlvErr", pSlvErr, expErr);
		nextCycle();
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
	endtask

	task automatic apbRead(input apbAddrT addr, input logic expErr, output apbDataT data);
		pSel = 1'b1;
		pEnable = 1'b0;
		pWrite = 1'b0;
		pAddr = addr;
		nextCycle();
		pEnable = 1'b1;
		#1;
		checkValue("pReady", pReady, 1'b1);
		checkValue("pSlvErr", pSlvErr, expErr);
		data = pRData;
		nextCycle();
		pSel = 1'b0;
		pEnable = 1'b0;
	endtask

	task automatic waitForRinging(input logic level, input int maxCycles);
		int cycles;
		cycles = 0;
		while (ringing !== level && cycles < maxCycles) begin
			nextCycle();
			cycles++;
		end
	endtask

	task automatic reportTest(input string name, input int startErr);
		$display("%s test done, %0d errors", name, errCount - startErr);
	endtask

	task automatic testRegisters();
		int startErr;
		int i;
		int sec;
		int minutes;
		apbDataT wdata;
		apbDataT rdata;
		apbDataT expAlarm;
		startErr = errCount;
		checkValue("ringing", ringing, 1'b0); // reset state
		checkValue("audioOut", audioOut, 1'b1);
		checkValue("an", an, 8'hfe);
		checkValue("pSlvErr", pSlvErr, 1'b0);
		apbRead(CTRL_ADDR, 1'b0, rdata);
		checkValue("CTRL", rdata, 32'h0);
		for (i = 0; i < 8; i++) begin
			wdata = $urandom();
			if (i == 0)
				wdata[13:0] = 14'h3f3e; // both fields above 59
			sec = (wdata[5:0] > MAX_SIXTY) ? MAX_SIXTY : wdata[5:0];
			minutes = (wdata[13:8] > MAX_SIXTY) ? MAX_SIXTY : wdata[13:8];
			expAlarm = timeWord(minutes, sec);
			apbWrite(ALARM_ADDR, wdata, 1'b0);
			apbRead(ALARM_ADDR, 1'b0, rdata);
			checkValue("ALARM", rdata, expAlarm);
		end
		apbWrite(CTRL_ADDR, 32'hffff_fff1, 1'b0);
		apbRead(CTRL_ADDR, 1'b0, rdata);
		checkValue("CTRL", rdata, 32'h1);
		apbWrite(4'h6, 32'h0000_0000, 1'b1); // unused offset
		apbRead(4'h2, 1'b1, rdata);
		checkValue("pRData", rdata, 32'h0);
		apbWrite(STATUS_ADDR, 32'hffff_ffff, 1'b1);
		apbWrite(4'h5, 32'h0000_0000, 1'b1);
		apbRead(ALARM_ADDR, 1'b0, rdata);
		checkValue("ALARM", rdata, expAlarm);
		apbRead(CTRL_ADDR, 1'b0, rdata);
		checkValue("CTRL", rdata, 32'h1);
		apbRead(STATUS_ADDR, 1'b0, rdata);
		checkValue("STATUS", rdata, 32'h0);
		apbWrite(CTRL_ADDR, 32'h0, 1'b0);
		reportTest("registers", startErr);
	endtask

	task automatic testTimekeeping();
		int startErr;
		apbDataT rdata;
		startErr = errCount;
		apbWrite(TIME_ADDR, timeWord(58, 57), 1'b0);
		// read sees 4 s minus one cycle of edges, so 3 or 4 ticks
		repeat (4 * CLKS_PER_SEC - 2) nextCycle();
		apbRead(TIME_ADDR, 1'b0, rdata);
		checkEither("TIME", rdata, timeAfter(58, 57, 3), timeAfter(58, 57, 4));
		apbWrite(TIME_ADDR, timeWord(59, 59), 1'b0);
		repeat (2 * CLKS_PER_SEC - 2) nextCycle();
		apbRead(TIME_ADDR, 1'b0, rdata);
		checkEither("TIME", rdata, timeWord(0, 0), timeWord(0, 1));
		reportTest("timekeeping", startErr);
	endtask

	task automatic testDisplay();
		int startErr;
		int cycles;
		int idx;
		int k;
		int value;
		int digit;
		bit [7:0] seen;
		apbDataT t0;
		apbDataT rdata;
		startErr = errCount;
		apbWrite(ALARM_ADDR, timeWord(53, 6), 1'b0);
		// sync to a second boundary so the time holds during the scan
		apbRead(TIME_ADDR, 1'b0, t0);
		rdata = t0;
		cycles = 0;
		while (rdata === t0 && cycles < 2 * CLKS_PER_SEC) begin
			apbRead(TIME_ADDR, 1'b0, rdata);
			cycles += 2;
		end
		apbWrite(TIME_ADDR, timeWord(26, 48), 1'b0);
		seen = '0;
		cycles = 0;
		while (seen !== 8'hff && cycles < 3 * 8 * CLKS_PER_DIGIT) begin
			checkTrue($countones(~an) == 1, $sformatf("an 0x%0h does not have one digit low", an));
			idx = -1;
			for (k = 0; k < 8; k++)
				if (an[k] === 1'b0)
					idx = k;
			if (idx >= 0) begin
				case (idx / 2)
					0: value = 48;
					1: value = 26;
					2: value = 6;
					default: value = 53;
				endcase
				digit = (idx % 2) ? value / 10 : value % 10;
				checkValue("seg", seg, segDigits[digit]);
				checkValue("dp", dp, (idx == 2 || idx == 6) ? 1'b0 : 1'b1);
				seen[idx] = 1'b1;
			end
			nextCycle();
			cycles++;
		end
		checkTrue(seen === 8'hff, "display scan did not reach all eight digits");
		reportTest("display", startErr);
	endtask

	task automatic testAlarmRing();
		int startErr;
		int halfLen;
		int ringCycles;
		bit quiet;
		apbDataT rdata;
		startErr = errCount;
		apbWrite(ALARM_ADDR, timeWord(0, 7), 1'b0);
		apbWrite(TIME_ADDR, timeWord(0, 5), 1'b0);
		apbWrite(CTRL_ADDR, 32'h1, 1'b0);
		waitForRinging(1'b1, 3 * CLKS_PER_SEC);
		checkTrue(ringing === 1'b1, "ringing did not rise within three seconds");
		halfLen = 0;
		while (audioOut === 1'b1 && halfLen < 4 * melodyHalfPeriod[0]) begin
			nextCycle();
			halfLen++;
		end
		checkValue("audioOut high time", halfLen, melodyHalfPeriod[0]);
		ringCycles = halfLen;
		halfLen = 0;
		while (audioOut === 1'b0 && halfLen < 4 * melodyHalfPeriod[0]) begin
			nextCycle();
			halfLen++;
		end
		checkValue("audioOut low time", halfLen, melodyHalfPeriod[0]);
		ringCycles += halfLen;
		apbRead(STATUS_ADDR, 1'b0, rdata);
		checkValue("STATUS", rdata, 32'h1); // still ringing
		ringCycles += 2;
		while (ringing === 1'b1 && ringCycles < (RING_SECONDS + 2) * CLKS_PER_SEC) begin
			nextCycle();
			ringCycles++;
		end
		checkTrue(ringing === 1'b0 && ringCycles >= (RING_SECONDS - 1) * CLKS_PER_SEC &&
			ringCycles <= (RING_SECONDS + 1) * CLKS_PER_SEC,
			$sformatf("ring lasted %0d cycles, not %0d seconds", ringCycles, RING_SECONDS));
		quiet = 1'b1;
		repeat (CLKS_PER_SEC / 2) begin
			if (audioOut !== 1'b1)
				quiet = 1'b0;
			nextCycle();
		end
		checkTrue(quiet, "audioOut moved after ringing ended");
		apbRead(STATUS_ADDR, 1'b0, rdata);
		checkValue("STATUS", rdata, 32'h0);
		apbWrite(CTRL_ADDR, 32'h0, 1'b0);
		reportTest("alarm ring", startErr);
	endtask

	task automatic testDisable();
		int startErr;
		bit quiet;
		startErr = errCount;
		apbWrite(TIME_ADDR, timeWord(0, 5), 1'b0);
		apbWrite(CTRL_ADDR, 32'h1, 1'b0);
		waitForRinging(1'b1, 3 * CLKS_PER_SEC);
		checkTrue(ringing === 1'b1, "ringing did not rise within three seconds");
		repeat (30) nextCycle(); // let the tone run
		apbWrite(CTRL_ADDR, 32'h0, 1'b0);
		checkValue("ringing", ringing, 1'b1); // enable just dropped
		nextCycle();
		checkValue("ringing", ringing, 1'b0);
		quiet = 1'b1;
		repeat (2 * CLKS_PER_NOTE) begin
			if (audioOut !== 1'b1 || ringing !== 1'b0)
				quiet = 1'b0;
			nextCycle();
		end
		checkTrue(quiet, "audioOut or ringing active after the alarm was disabled");
		reportTest("disable", startErr);
	endtask

	initial begin
		void'($urandom(32'h0c12_8d9d));
		errCount = 0;
		checkCount = 0;
		rstN = 1'b0;
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
		pAddr = '0;
		pWData = '0;
		repeat (5) @(posedge Clk);
		#1;
		rstN = 1'b1;
		testRegisters();
		testTimekeeping();
		testDisplay();
		testAlarmRing();
		testDisable();
		$display("%0d checks, %0d errors", checkCount, errCount);
		if (errCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: all.f
hdl/alarmPkg.sv
hdl/alarmRegs.sv
hdl/tickGen.sv
hdl/timeCounter.sv
hdl/alarmControl.sv
hdl/toneGen.sv
hdl/displayScan.sv
hdl/alarmClockTop.sv
verif/alarmClockTb.sv
